// ==== flist.f ====
hw/mem_types_pkg.sv
hw/host_chan_pkg.sv
hw/read_rsp_sorter.sv
hw/client_mem_port.sv
hw/mem_driver_top.sv
test/host_mem_model.sv
test/mem_driver_tb.sv

// ==== hw/client_mem_port.sv ====
// Client request port that merges reads and writes onto the credited host request channel

`timescale 1ns/100ps

module client_mem_port
(
    input  logic                       clk,
    input  logic                       reset_n,

    // Client read request
    input  mem_types_pkg::line_addr_t  mem_read_req_addr,
    input  logic                       mem_read_req_cached,
    input  logic                       mem_read_req_enable,
    output logic                       mem_read_req_rdy,

    // Client write request and completion count
    input  mem_types_pkg::line_addr_t  mem_write_addr,
    input  mem_types_pkg::line_data_t  mem_write_data,
    input  logic                       mem_write_cached,
    input  logic                       mem_write_enable,
    output logic                       mem_write_rdy,
    output mem_types_pkg::wr_ack_cnt_t mem_write_ack,

    // Host request channel
    output logic                       host_req_valid,
    output host_chan_pkg::host_opcode_t host_req_opcode,
    output mem_types_pkg::line_addr_t  host_req_addr,
    output host_chan_pkg::rd_tag_t     host_req_tag,
    output mem_types_pkg::line_data_t  host_req_data,

    // Host credit and write completion returns
    input  logic                       host_credit_return,
    input  logic                       host_wr_ack_a,
    input  logic                       host_wr_ack_b,

    // Tag allocation handshake with the response sorter
    input  logic                       tag_avail,
    input  host_chan_pkg::rd_tag_t     next_tag,
    output logic                       rd_issue
);

    import mem_types_pkg::*;
    import host_chan_pkg::*;

    credit_cnt_t  credit_cnt;
    logic         credit_avail;
    logic         wr_go;
    logic         rd_go;
    host_opcode_t rd_opcode;
    host_opcode_t wr_opcode;

    // ========================================================================
    //  Credits and ready
    // ========================================================================

    // Any request, read or write, costs exactly one host credit
    assign credit_avail = (credit_cnt != '0);

    // A write needs only a credit
    assign mem_write_rdy = credit_avail;

    // Reads also need a free tag, and they yield the cycle to a pending write
    assign mem_read_req_rdy = credit_avail && tag_avail && !mem_write_enable;

    // Enables are qualified again here so a misbehaving client cannot overdraw
    assign wr_go = mem_write_enable && credit_avail;
    assign rd_go = mem_read_req_enable && mem_read_req_rdy;

    // The sorter moves its allocation pointer on this pulse
    assign rd_issue = rd_go;

    // Count goes down on an accepted request and up on each returned credit;
    // both can happen in the same cycle and then cancel out
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            credit_cnt <= credit_cnt_t'(HOST_CREDITS);
        end
        else
        begin
            credit_cnt <= credit_cnt - credit_cnt_t'(wr_go || rd_go)
                                     + credit_cnt_t'(host_credit_return);
        end
    end

    // ========================================================================
    //  Host request register
    // ========================================================================

    // The cached flag only picks between the two forms of each opcode
    assign rd_opcode = mem_read_req_cached ? OP_RDLINE_CACHED : OP_RDLINE_UNCACHED;
    assign wr_opcode = mem_write_cached ? OP_WRLINE_CACHED : OP_WRLINE_UNCACHED;

    // Valid marks the single cycle that carries a new host request
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            host_req_valid <= 1'b0;
        end
        else
        begin
            host_req_valid <= wr_go || rd_go;
        end
    end

    // Header and data hold their value between requests
    always_ff @(posedge clk)
    begin
        if (wr_go)
        begin
            host_req_opcode <= wr_opcode;
            host_req_addr   <= mem_write_addr;
            host_req_tag    <= '0;
            host_req_data   <= mem_write_data;
        end
        else if (rd_go)
        begin
            // Read data field is unused by the host, so it is zeroed
            host_req_opcode <= rd_opcode;
            host_req_addr   <= mem_read_req_addr;
            host_req_tag    <= next_tag;
            host_req_data   <= '0;
        end
    end

    // ========================================================================
    //  Write completion count
    // ========================================================================

    // Both ack lines may pulse together, giving a count of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_write_ack <= '0;
        end
        else
        begin
            mem_write_ack <= wr_ack_cnt_t'(host_wr_ack_a) + wr_ack_cnt_t'(host_wr_ack_b);
        end
    end

endmodule

// ==== hw/host_chan_pkg.sv ====
// Host channel definitions for tags, request opcodes and credits, shared by driver and host model

package host_chan_pkg;

    // ========================================================================
    //  Read tags
    // ========================================================================

    // Tag carried by a read request and echoed back with its response
    typedef logic [3:0] rd_tag_t;

    // One tag per buffer slot in the response sorter
    localparam int MAX_OUTSTANDING_RD = 16;

    // ========================================================================
    //  Request opcodes
    // ========================================================================

    typedef logic [1:0] host_opcode_t;

    // Bit 1 selects write, bit 0 selects the uncached form
    localparam host_opcode_t OP_RDLINE_CACHED   = 2'b00;
    localparam host_opcode_t OP_RDLINE_UNCACHED = 2'b01;
    localparam host_opcode_t OP_WRLINE_CACHED   = 2'b10;
    localparam host_opcode_t OP_WRLINE_UNCACHED = 2'b11;

    // ========================================================================
    //  Credit pool
    // ========================================================================

    // The host grants this many request credits after reset
    localparam int HOST_CREDITS = 8;

    // Wide enough to hold a full pool, 0 to HOST_CREDITS
    typedef logic [3:0] credit_cnt_t;

endpackage

// ==== hw/mem_driver_top.sv ====
// Memory driver top level, instanced by the testbench or a client between it and the host

`timescale 1ns/100ps

module mem_driver_top
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Client read request and response
    input  mem_types_pkg::line_addr_t   mem_read_req_addr,
    input  logic                        mem_read_req_cached,
    input  logic                        mem_read_req_enable,
    output logic                        mem_read_req_rdy,
    output mem_types_pkg::line_data_t   mem_read_rsp_data,
    output logic                        mem_read_rsp_valid,

    // Client write
    input  mem_types_pkg::line_addr_t   mem_write_addr,
    input  mem_types_pkg::line_data_t   mem_write_data,
    input  logic                        mem_write_cached,
    input  logic                        mem_write_enable,
    output logic                        mem_write_rdy,
    output mem_types_pkg::wr_ack_cnt_t  mem_write_ack,

    // Host request channel
    output logic                        host_req_valid,
    output host_chan_pkg::host_opcode_t host_req_opcode,
    output mem_types_pkg::line_addr_t   host_req_addr,
    output host_chan_pkg::rd_tag_t      host_req_tag,
    output mem_types_pkg::line_data_t   host_req_data,

    // Host returns
    input  logic                        host_credit_return,
    input  logic                        host_rd_rsp_valid,
    input  host_chan_pkg::rd_tag_t      host_rd_rsp_tag,
    input  mem_types_pkg::line_data_t   host_rd_rsp_data,
    input  logic                        host_wr_ack_a,
    input  logic                        host_wr_ack_b
);

    import host_chan_pkg::*;

    logic    tag_avail;
    rd_tag_t next_tag;
    logic    rd_issue;

    // ========================================================================
    //  Read response sorting, nearest the host
    // ========================================================================

    read_rsp_sorter sorter_i
    (
        .clk,
        .reset_n,
        .rd_issue,
        .tag_avail,
        .next_tag,
        .host_rd_rsp_valid,
        .host_rd_rsp_tag,
        .host_rd_rsp_data,
        .mem_read_rsp_data,
        .mem_read_rsp_valid
    );

    // ========================================================================
    //  Client requests onto the credited host channel
    // ========================================================================

    client_mem_port port_i
    (
        .clk,
        .reset_n,
        .mem_read_req_addr,
        .mem_read_req_cached,
        .mem_read_req_enable,
        .mem_read_req_rdy,
        .mem_write_addr,
        .mem_write_data,
        .mem_write_cached,
        .mem_write_enable,
        .mem_write_rdy,
        .mem_write_ack,
        .host_req_valid,
        .host_req_opcode,
        .host_req_addr,
        .host_req_tag,
        .host_req_data,
        .host_credit_return,
        .host_wr_ack_a,
        .host_wr_ack_b,
        .tag_avail,
        .next_tag,
        .rd_issue
    );

endmodule

// ==== hw/mem_types_pkg.sv ====
// Client-side memory types, imported by the RTL and testbench for client line transfers

package mem_types_pkg;

    // ========================================================================
    //  Line addressing and payload
    // ========================================================================

    // Memory is addressed in whole 64-bit lines, never in bytes
    typedef logic [25:0] line_addr_t;

    // One full line of data as seen by the client
    typedef logic [63:0] line_data_t;

    // ========================================================================
    //  Write completion
    // ========================================================================

    // Writes retired in one cycle; two host ack lines give a range of 0 to 2
    typedef logic [1:0] wr_ack_cnt_t;

endpackage

// ==== hw/read_rsp_sorter.sv ====
// Read response sorter that allocates tags and returns host read data in request order

`timescale 1ns/100ps

module read_rsp_sorter
(
    input  logic                      clk,
    input  logic                      reset_n,

    // Tag allocation, driven toward the client port
    input  logic                      rd_issue,
    output logic                      tag_avail,
    output host_chan_pkg::rd_tag_t    next_tag,

    // Unordered responses from the host
    input  logic                      host_rd_rsp_valid,
    input  host_chan_pkg::rd_tag_t    host_rd_rsp_tag,
    input  mem_types_pkg::line_data_t host_rd_rsp_data,

    // In-order responses to the client
    output mem_types_pkg::line_data_t mem_read_rsp_data,
    output logic                      mem_read_rsp_valid
);

    import mem_types_pkg::*;
    import host_chan_pkg::*;

    // Outstanding reads range from 0 to a full ring, one bit wider than a tag
    typedef logic [$clog2(MAX_OUTSTANDING_RD):0] rd_count_t;

    rd_tag_t    alloc_ptr;
    rd_tag_t    head_ptr;
    rd_count_t  rd_outstanding;
    logic       head_deliver;

    // One slot per tag, plus a valid bit per slot
    line_data_t                    rsp_buf [MAX_OUTSTANDING_RD];
    logic [MAX_OUTSTANDING_RD-1:0] rsp_valid;

    // ========================================================================
    //  Tag allocation
    // ========================================================================

    // Tags are handed out in ring order, so the head pointer always names
    // the oldest read that has not yet been delivered
    assign next_tag  = alloc_ptr;
    assign tag_avail = (rd_outstanding < rd_count_t'(MAX_OUTSTANDING_RD));

    // A tag stays busy until its line leaves the buffer, not when the host answers
    assign head_deliver = rsp_valid[head_ptr];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr      <= '0;
            head_ptr       <= '0;
            rd_outstanding <= '0;
        end
        else
        begin
            if (rd_issue)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (head_deliver)
            begin
                head_ptr <= head_ptr + 1'b1;
            end

            rd_outstanding <= rd_outstanding + rd_count_t'(rd_issue)
                                             - rd_count_t'(head_deliver);
        end
    end

    // ========================================================================
    //  Response buffer
    // ========================================================================

    // The set and clear never hit the same slot in one cycle, because a
    // delivered tag cannot still be in flight
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= '0;
        end
        else
        begin
            if (head_deliver)
            begin
                rsp_valid[head_ptr] <= 1'b0;
            end

            if (host_rd_rsp_valid)
            begin
                rsp_valid[host_rd_rsp_tag] <= 1'b1;
            end
        end
    end

    // Line storage, written by tag as responses arrive
    always_ff @(posedge clk)
    begin
        if (host_rd_rsp_valid)
        begin
            rsp_buf[host_rd_rsp_tag] <= host_rd_rsp_data;
        end
    end

    // ========================================================================
    //  Ordered output
    // ========================================================================

    // Output valid pulses once per delivered line
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_read_rsp_valid <= 1'b0;
        end
        else
        begin
            mem_read_rsp_valid <= head_deliver;
        end
    end

    // The head line moves to the output register as it is delivered
    always_ff @(posedge clk)
    begin
        if (head_deliver)
        begin
            mem_read_rsp_data <= rsp_buf[head_ptr];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory driver testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module mem_driver_tb -o mem_driver_sim
./obj_dir/mem_driver_sim > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== test/host_mem_model.sv ====
// Behavioral host memory for the testbench, granting credits and answering requests out of order

`timescale 1ns/100ps

module host_mem_model
(
    input  logic                        clk,
    input  logic                        freeze_credits,

    // Requests from the DUT
    input  logic                        host_req_valid,
    input  host_chan_pkg::host_opcode_t host_req_opcode,
    input  mem_types_pkg::line_addr_t   host_req_addr,
    input  host_chan_pkg::rd_tag_t      host_req_tag,
    input  mem_types_pkg::line_data_t   host_req_data,

    // Returns to the DUT
    output logic                        host_credit_return,
    output logic                        host_rd_rsp_valid,
    output host_chan_pkg::rd_tag_t      host_rd_rsp_tag,
    output mem_types_pkg::line_data_t   host_rd_rsp_data,
    output logic                        host_wr_ack_a,
    output logic                        host_wr_ack_b
);

    import mem_types_pkg::*;
    import host_chan_pkg::*;

    localparam line_data_t FILL_MASK = 64'h5A5A_C3C3_0FF0_9669;

    line_data_t mem [line_addr_t];
    int         cycle;
    logic       frozen;

    // Pending reads live in three matching queues, one entry per read
    int         rd_due [$];
    rd_tag_t    rd_tag [$];
    line_data_t rd_data [$];

    // Cycles at which write acks and credit returns fall due
    int         wr_due [$];
    int         cr_due [$];

    // Unwritten lines read back as the address spread over the line
    function automatic line_data_t read_line(input line_addr_t addr);
        line_data_t value;
        if (mem.exists(addr))
        begin
            value = mem[addr];
        end
        else
        begin
            value = {addr[11:0], addr, addr} ^ FILL_MASK;
        end
        return value;
    endfunction

    // Index of the first entry that is due, or -1; the queues are not sorted by due cycle
    function automatic int first_due(input int due_q[$], input int now);
        int idx;
        idx = -1;
        for (int i = 0; i < due_q.size(); i++)
        begin
            if (idx < 0 && due_q[i] <= now)
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Freeze takes effect from the cycle after the testbench raises it
    always @(posedge clk)
    begin
        frozen <= freeze_credits;
    end

    // ========================================================================
    //  Request intake and returns, once per cycle
    // ========================================================================

    initial
    begin
        int idx;
        int done;
        host_credit_return = 1'b0;
        host_rd_rsp_valid  = 1'b0;
        host_rd_rsp_tag    = '0;
        host_rd_rsp_data   = '0;
        host_wr_ack_a      = 1'b0;
        host_wr_ack_b      = 1'b0;
        cycle              = 0;
        forever
        begin
            @(posedge clk);
            #2;
            cycle++;
            host_credit_return = 1'b0;
            host_rd_rsp_valid  = 1'b0;
            host_wr_ack_a      = 1'b0;
            host_wr_ack_b      = 1'b0;

            // Every request holds a credit until its random return cycle
            if (host_req_valid)
            begin
                cr_due.push_back(cycle + 1 + int'($urandom_range(0, 5)));
                if (host_req_opcode == OP_WRLINE_CACHED || host_req_opcode == OP_WRLINE_UNCACHED)
                begin
                    mem[host_req_addr] = host_req_data;
                    wr_due.push_back(cycle + int'($urandom_range(1, 8)));
                end
                else
                begin
                    rd_due.push_back(cycle + int'($urandom_range(1, 12)));
                    rd_tag.push_back(host_req_tag);
                    rd_data.push_back(read_line(host_req_addr));
                end
            end

            // At most one read response per cycle, the first one that is due
            idx = first_due(rd_due, cycle);
            if (idx >= 0)
            begin
                host_rd_rsp_valid = 1'b1;
                host_rd_rsp_tag   = rd_tag[idx];
                host_rd_rsp_data  = rd_data[idx];
                rd_due.delete(idx);
                rd_tag.delete(idx);
                rd_data.delete(idx);
            end

            // Up to two write acks; a single one goes out on a random line
            done = 0;
            idx  = first_due(wr_due, cycle);
            while (idx >= 0 && done < 2)
            begin
                wr_due.delete(idx);
                done++;
                idx = first_due(wr_due, cycle);
            end
            if (done == 2)
            begin
                host_wr_ack_a = 1'b1;
                host_wr_ack_b = 1'b1;
            end
            else if (done == 1)
            begin
                host_wr_ack_a = ($urandom_range(0, 1) == 0);
                host_wr_ack_b = !host_wr_ack_a;
            end

            // One credit per pulse, held back entirely while frozen
            idx = first_due(cr_due, cycle);
            if (!frozen && idx >= 0)
            begin
                host_credit_return = 1'b1;
                cr_due.delete(idx);
            end
        end
    end

endmodule

// ==== test/mem_driver_tb.sv ====
// Testbench top for the memory driver, compiled with the RTL and the host model from the file list

`timescale 1ns/100ps

module mem_driver_tb;

    import mem_types_pkg::*;
    import host_chan_pkg::*;

    localparam int         WAIT_LIMIT  = 200;
    localparam int         DRAIN_LIMIT = 1000;
    localparam line_data_t FILL_MASK   = 64'h5A5A_C3C3_0FF0_9669;

    logic         clk;
    logic         reset_n;
    line_addr_t   mem_read_req_addr;
    logic         mem_read_req_cached;
    logic         mem_read_req_enable;
    logic         mem_read_req_rdy;
    line_data_t   mem_read_rsp_data;
    logic         mem_read_rsp_valid;
    line_addr_t   mem_write_addr;
    line_data_t   mem_write_data;
    logic         mem_write_cached;
    logic         mem_write_enable;
    logic         mem_write_rdy;
    wr_ack_cnt_t  mem_write_ack;
    logic         host_req_valid;
    host_opcode_t host_req_opcode;
    line_addr_t   host_req_addr;
    rd_tag_t      host_req_tag;
    line_data_t   host_req_data;
    logic         host_credit_return;
    logic         host_rd_rsp_valid;
    rd_tag_t      host_rd_rsp_tag;
    line_data_t   host_rd_rsp_data;
    logic         host_wr_ack_a;
    logic         host_wr_ack_b;
    logic         freeze_credits;
    logic         in_freeze;

    // Expected state, built from the requests the testbench has issued
    line_data_t   written [line_addr_t];
    line_data_t   exp_rsp_q [$];
    host_opcode_t exp_op_q [$];
    int           writes_issued;
    int           acks_total;
    int           freeze_reqs;
    int           credits_out;
    int           seq_errors;
    int           rsp_errors;
    int           req_errors;

    mem_driver_top dut_i (.*);

    host_mem_model host_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // Last data written to a line, or the fill pattern if it was never written
    function automatic line_data_t expected_line(input line_addr_t addr);
        line_data_t value;
        if (written.exists(addr))
        begin
            value = written[addr];
        end
        else
        begin
            value = {addr[11:0], addr, addr} ^ FILL_MASK;
        end
        return value;
    endfunction

    // Advance to the drive point 2 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Drive one write for one cycle; the caller has already seen mem_write_rdy high
    task automatic push_write(input line_addr_t addr, input line_data_t data, input logic cached);
        mem_write_addr   = addr;
        mem_write_data   = data;
        mem_write_cached = cached;
        mem_write_enable = 1'b1;
        written[addr]    = data;
        writes_issued++;
        exp_op_q.push_back(cached ? OP_WRLINE_CACHED : OP_WRLINE_UNCACHED);
        next_cycle();
        mem_write_enable = 1'b0;
    endtask

    task automatic do_write(input line_addr_t addr, input line_data_t data, input logic cached);
        int waited;
        waited = 0;
        while (!mem_write_rdy && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!mem_write_rdy)
        begin
            seq_errors++;
            $display("%0t: write to line %h never saw mem_write_rdy", $time, addr);
        end
        else
        begin
            push_write(addr, data, cached);
        end
    endtask

    // Each accepted read queues the line the client should see for it
    task automatic do_read(input line_addr_t addr, input logic cached);
        int waited;
        waited = 0;
        while (!mem_read_req_rdy && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!mem_read_req_rdy)
        begin
            seq_errors++;
            $display("%0t: read of line %h never saw mem_read_req_rdy", $time, addr);
        end
        else
        begin
            mem_read_req_addr   = addr;
            mem_read_req_cached = cached;
            mem_read_req_enable = 1'b1;
            exp_rsp_q.push_back(expected_line(addr));
            exp_op_q.push_back(cached ? OP_RDLINE_CACHED : OP_RDLINE_UNCACHED);
            next_cycle();
            mem_read_req_enable = 1'b0;
        end
    endtask

    // Wait until every read has returned and every write is acknowledged
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_rsp_q.size() != 0 || acks_total != writes_issued) && waited < DRAIN_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (exp_rsp_q.size() != 0 || acks_total != writes_issued)
        begin
            seq_errors++;
            $display("%0t: drain timed out with %0d reads and %0d write acks outstanding",
                     $time, exp_rsp_q.size(), writes_issued - acks_total);
        end
    endtask

    // ========================================================================
    //  Read response comparison and write ack accounting
    // ========================================================================

    initial
    begin
        line_data_t expected;
        rsp_errors = 0;
        acks_total = 0;
        forever
        begin
            @(negedge clk);
            acks_total += int'(mem_write_ack);
            if (mem_read_rsp_valid)
            begin
                if (exp_rsp_q.size() == 0)
                begin
                    rsp_errors++;
                    $display("%0t: read response arrived with no read outstanding", $time);
                end
                else
                begin
                    expected = exp_rsp_q.pop_front();
                    if (mem_read_rsp_data !== expected)
                    begin
                        rsp_errors++;
                        $display("MISMATCH %0t mem_read_rsp_data expected %h got %h",
                                 $time, expected, mem_read_rsp_data);
                    end
                end
            end
        end
    end

    // ========================================================================
    //  Host request opcodes and client handshake rules
    // ========================================================================

    initial
    begin
        host_opcode_t expected_op;
        req_errors  = 0;
        freeze_reqs = 0;
        credits_out = 0;
        forever
        begin
            @(negedge clk);
            if (mem_write_enable && !mem_write_rdy)
            begin
                req_errors++;
                $display("%0t: mem_write_enable was raised while mem_write_rdy was low", $time);
            end
            if (mem_read_req_enable && !mem_read_req_rdy)
            begin
                req_errors++;
                $display("%0t: mem_read_req_enable was raised while mem_read_req_rdy was low",
                         $time);
            end
            if (host_req_valid)
            begin
                credits_out++;
                if (in_freeze)
                begin
                    freeze_reqs++;
                end
                if (exp_op_q.size() == 0)
                begin
                    req_errors++;
                    $display("%0t: host request seen with no client request behind it", $time);
                end
                else
                begin
                    expected_op = exp_op_q.pop_front();
                    if (host_req_opcode !== expected_op)
                    begin
                        req_errors++;
                        $display("MISMATCH %0t host_req_opcode expected %h got %h",
                                 $time, expected_op, host_req_opcode);
                    end
                end
            end
            // Credits held by the host, one per request until its return pulse
            if (host_credit_return)
            begin
                credits_out--;
            end
        end
    end

    // ========================================================================
    //  Stimulus sequence
    // ========================================================================

    initial
    begin
        int accepted;
        int waited;
        void'($urandom(50));
        reset_n             = 1'b0;
        mem_read_req_addr   = '0;
        mem_read_req_cached = 1'b0;
        mem_read_req_enable = 1'b0;
        mem_write_addr      = '0;
        mem_write_data      = '0;
        mem_write_cached    = 1'b0;
        mem_write_enable    = 1'b0;
        freeze_credits      = 1'b0;
        in_freeze           = 1'b0;
        writes_issued       = 0;
        seq_errors          = 0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Nothing moves on the outputs before the first request
        repeat (3)
        begin
            next_cycle();
            if (host_req_valid !== 1'b0)
            begin
                seq_errors++;
                $display("MISMATCH %0t host_req_valid expected 0 got %b", $time, host_req_valid);
            end
            if (mem_read_rsp_valid !== 1'b0)
            begin
                seq_errors++;
                $display("MISMATCH %0t mem_read_rsp_valid expected 0 got %b",
                         $time, mem_read_rsp_valid);
            end
            if (mem_write_ack !== '0)
            begin
                seq_errors++;
                $display("MISMATCH %0t mem_write_ack expected 0 got %0d", $time, mem_write_ack);
            end
        end

        // Written lines read back their data, unwritten ones the fill pattern
        for (int i = 0; i < 8; i++)
        begin
            do_write(line_addr_t'(26'h100 + i), {$urandom, $urandom}, i[0]);
        end
        for (int i = 0; i < 12; i++)
        begin
            do_read(line_addr_t'((i < 8) ? 26'h100 + i : 26'h200 + i), !i[0]);
        end

        // Read burst with random host latency, so responses return out of order
        for (int i = 0; i < 40; i++)
        begin
            do_read(line_addr_t'(26'h100 + $urandom_range(0, 31)), 1'($urandom_range(0, 1)));
        end
        wait_drain();

        // Starve the pool with credit returns frozen, starting from a full pool
        waited = 0;
        while (credits_out != 0 && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (credits_out != 0)
        begin
            seq_errors++;
            $display("%0t: host still held %0d credits before the freeze", $time, credits_out);
        end
        freeze_credits = 1'b1;
        in_freeze      = 1'b1;
        accepted       = 0;
        while (mem_write_rdy && accepted < HOST_CREDITS + 4)
        begin
            push_write(line_addr_t'(26'h300 + accepted), {$urandom, $urandom}, 1'b1);
            accepted++;
        end
        if (mem_write_rdy)
        begin
            seq_errors++;
            $display("%0t: mem_write_rdy stayed high with credit return frozen", $time);
        end
        repeat (16)
        begin
            next_cycle();
            if (mem_write_rdy || mem_read_req_rdy)
            begin
                seq_errors++;
                $display("%0t: a ready output rose while no credit was free", $time);
            end
        end
        if (freeze_reqs > HOST_CREDITS)
        begin
            seq_errors++;
            $display("MISMATCH %0t host_req_valid count expected at most %0d got %0d",
                     $time, HOST_CREDITS, freeze_reqs);
        end
        in_freeze      = 1'b0;
        freeze_credits = 1'b0;
        waited         = 0;
        while (!(mem_write_rdy && mem_read_req_rdy) && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!(mem_write_rdy && mem_read_req_rdy))
        begin
            seq_errors++;
            $display("%0t: ready outputs did not recover after credits were released", $time);
        end

        // Every write issued must be acknowledged exactly once
        wait_drain();
        repeat (5) next_cycle();
        if (acks_total != writes_issued)
        begin
            seq_errors++;
            $display("MISMATCH %0t mem_write_ack total expected %0d got %0d",
                     $time, writes_issued, acks_total);
        end

        $display("Error counts: sequence %0d, read data %0d, host request %0d",
                 seq_errors, rsp_errors, req_errors);
        if (seq_errors + rsp_errors + req_errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
